/* hw/fx3_settings.svh */
`ifndef FX3_SETTINGS_SVH
`define FX3_SETTINGS_SVH

// slave fifo data bus width in bits
`define FX3_DATA_W 16

// words moved per loop
`define FX3_BURST_LEN 32

// loop fifo depth, must hold at least one burst
`define FX3_FIFO_DEPTH 32

// fx3 cycles from a sampled slrd to valid data on the bus
`define FX3_RD_LAT 2

// idle cycles between the end of stream out and stream in
`define FX3_TURNAROUND 10

`endif

/* hw/fx3_pkg.sv */
`default_nettype none

`include "fx3_settings.svh"

package fx3_pkg;

    // one slave fifo bus word
    typedef logic [`FX3_DATA_W-1:0] fx3_word_t;

    // master modes
    typedef enum logic [1:0] {
        mode_idle       = 2'd0,
        mode_stream_out = 2'd1,
        mode_turnaround = 2'd2,
        mode_stream_in  = 2'd3
    } fx3_mode_e;

    // socket address on A1/A0
    typedef enum logic [1:0] {
        addr_stream_in  = 2'd0,
        addr_parked     = 2'd2,
        addr_stream_out = 2'd3
    } fx3_addr_e;

    // led status code
    typedef enum logic [7:0] {
        status_idle       = 8'd0,
        status_stream_out = 8'd1,
        status_turnaround = 8'd2,
        status_stream_in  = 8'd3
    } fx3_status_t;

endpackage

`default_nettype wire

/* hw/fx3_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fx3_bus_if;

    // strobes toward the fx3, active low, before the pin registers
    logic slcs_n;
    logic slrd_n;
    logic sloe_n;
    logic slwr_n;

    fx3_pkg::fx3_addr_e addr;
    fx3_pkg::fx3_word_t wdata;

    // registered copies of the pins
    fx3_pkg::fx3_word_t rdata;
    logic flaga;
    logic flagb;
    logic flagc;
    logic flagd;

    modport engine (
        output slcs_n, slrd_n, sloe_n, slwr_n, addr, wdata,
        input  rdata, flaga, flagb, flagc, flagd
    );

    modport pin (
        input  slcs_n, slrd_n, sloe_n, slwr_n, addr, wdata,
        output rdata, flaga, flagb, flagc, flagd
    );

endinterface

`default_nettype wire

/* hw/fx3_pin_io.sv */
`timescale 1ns/1ps
`default_nettype none

module fx3_pin_io (
    input  logic               usb_clk,
    input  logic               reset_,
    input  logic               flaga_i,
    input  logic               flagb_i,
    input  logic               flagc_i,
    input  logic               flagd_i,
    input  fx3_pkg::fx3_word_t data_i,
    output logic               slcs_n_o,
    output logic               slrd_n_o,
    output logic               sloe_n_o,
    output logic               slwr_n_o,
    output fx3_pkg::fx3_addr_e addr_o,
    output fx3_pkg::fx3_word_t data_o,
    output logic               data_oe_o,
    fx3_bus_if.pin             bus
);

    // flags sampled once at the pins
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            bus.flaga <= 1'b0;
            bus.flagb <= 1'b0;
            bus.flagc <= 1'b0;
            bus.flagd <= 1'b0;
        end else begin
            bus.flaga <= flaga_i;
            bus.flagb <= flagb_i;
            bus.flagc <= flagc_i;
            bus.flagd <= flagd_i;
        end
    end

    // strobes idle high, address parked
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            slcs_n_o <= 1'b1;
            slrd_n_o <= 1'b1;
            sloe_n_o <= 1'b1;
            slwr_n_o <= 1'b1;
            addr_o   <= fx3_pkg::addr_parked;
        end else begin
            slcs_n_o <= bus.slcs_n;
            slrd_n_o <= bus.slrd_n;
            sloe_n_o <= bus.sloe_n;
            slwr_n_o <= bus.slwr_n;
            addr_o   <= bus.addr;
        end
    end

    always_ff @(posedge usb_clk) begin
        bus.rdata <= data_i;
        data_o    <= bus.wdata;
    end

    // drive the bus only in a write cycle
    assign data_oe_o = ~slwr_n_o;

    // read and write engines never overlap on the pins
    a_no_rd_wr_overlap: assert property (
        @(posedge usb_clk) disable iff (!reset_) slrd_n_o || slwr_n_o
    );

endmodule

`default_nettype wire

/* hw/fx3_mode_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fx3_settings.svh"

module fx3_mode_fsm (
    input  logic                 usb_clk,
    input  logic                 reset_,
    input  logic                 fifo_empty_i,
    input  logic                 read_done_i,
    input  logic                 write_done_i,
    output logic                 start_read_o,
    output logic                 start_write_o,
    output fx3_pkg::fx3_status_t led_o,
    fx3_bus_if.engine            bus
);

    localparam int TURN_W = $clog2(`FX3_TURNAROUND + 1);

    fx3_pkg::fx3_mode_e   mode;
    fx3_pkg::fx3_mode_e   mode_nxt;
    fx3_pkg::fx3_status_t status;
    logic [TURN_W-1:0]    turn_cnt;

    always_comb begin
        mode_nxt = mode;
        case (mode)
            fx3_pkg::mode_idle: begin
                // full packet waiting and nothing left from the last loop
                if (bus.flagc && bus.flagd && fifo_empty_i) begin
                    mode_nxt = fx3_pkg::mode_stream_out;
                end
            end
            fx3_pkg::mode_stream_out: begin
                if (read_done_i) begin
                    mode_nxt = fx3_pkg::mode_turnaround;
                end
            end
            fx3_pkg::mode_turnaround: begin
                if (turn_cnt == '0) begin
                    mode_nxt = fx3_pkg::mode_stream_in;
                end
            end
            fx3_pkg::mode_stream_in: begin
                if (write_done_i) begin
                    mode_nxt = fx3_pkg::mode_idle;
                end
            end
            default: mode_nxt = fx3_pkg::mode_idle;
        endcase
    end

    // socket and status follow the mode
    always_comb begin
        case (mode)
            fx3_pkg::mode_stream_out: begin
                bus.addr = fx3_pkg::addr_stream_out;
                status   = fx3_pkg::status_stream_out;
            end
            fx3_pkg::mode_turnaround: begin
                bus.addr = fx3_pkg::addr_parked;
                status   = fx3_pkg::status_turnaround;
            end
            fx3_pkg::mode_stream_in: begin
                bus.addr = fx3_pkg::addr_stream_in;
                status   = fx3_pkg::status_stream_in;
            end
            default: begin
                bus.addr = fx3_pkg::addr_parked;
                status   = fx3_pkg::status_idle;
            end
        endcase
    end

    assign bus.slcs_n = (mode == fx3_pkg::mode_idle);

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            mode          <= fx3_pkg::mode_idle;
            turn_cnt      <= '0;
            start_read_o  <= 1'b0;
            start_write_o <= 1'b0;
            led_o         <= fx3_pkg::status_idle;
        end else begin
            mode          <= mode_nxt;
            start_read_o  <= (mode == fx3_pkg::mode_idle) &&
                             (mode_nxt == fx3_pkg::mode_stream_out);
            start_write_o <= (mode == fx3_pkg::mode_turnaround) &&
                             (mode_nxt == fx3_pkg::mode_stream_in);
            led_o         <= status;
            // count the gap down from entry, leave at zero
            if (mode == fx3_pkg::mode_stream_out && read_done_i) begin
                turn_cnt <= TURN_W'(`FX3_TURNAROUND - 1);
            end else if (turn_cnt != '0) begin
                turn_cnt <= turn_cnt - 1'b1;
            end
        end
    end

    // the read burst must have landed before writing back
    a_write_needs_data: assert property (
        @(posedge usb_clk) disable iff (!reset_) start_write_o |-> !fifo_empty_i
    );

endmodule

`default_nettype wire

/* hw/fx3_stream_out.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fx3_settings.svh"

module fx3_stream_out (
    input  logic               usb_clk,
    input  logic               reset_,
    input  logic               start_read_i,
    output logic               push_o,
    output fx3_pkg::fx3_word_t push_data_o,
    output logic               read_done_o,
    fx3_bus_if.engine          bus
);

    // pin out, fx3 latency, pin in
    localparam int DLY   = `FX3_RD_LAT + 2;
    localparam int CNT_W = $clog2(`FX3_BURST_LEN + 1);

    logic             rd_active;
    logic [CNT_W-1:0] rd_cnt;
    logic [CNT_W-1:0] push_cnt;
    logic [DLY-1:0]   rd_pipe;

    assign bus.slrd_n = ~rd_active;
    assign bus.sloe_n = ~rd_active;

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            rd_active <= 1'b0;
            rd_cnt    <= '0;
        end else if (start_read_i) begin
            rd_active <= 1'b1;
            rd_cnt    <= '0;
        end else if (rd_active) begin
            rd_cnt <= rd_cnt + 1'b1;
            if (rd_cnt == CNT_W'(`FX3_BURST_LEN - 1)) begin
                rd_active <= 1'b0;
            end
        end
    end

    // one bit per read strobe still in flight
    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            rd_pipe <= '0;
        end else begin
            rd_pipe <= {rd_pipe[DLY-2:0], rd_active};
        end
    end

    assign push_o      = rd_pipe[DLY-1];
    assign push_data_o = bus.rdata;

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            push_cnt    <= '0;
            read_done_o <= 1'b0;
        end else begin
            read_done_o <= push_o && (push_cnt == CNT_W'(`FX3_BURST_LEN - 1));
            if (start_read_i) begin
                push_cnt <= '0;
            end else if (push_o) begin
                push_cnt <= push_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/fx3_stream_in.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fx3_settings.svh"

module fx3_stream_in (
    input  logic               usb_clk,
    input  logic               reset_,
    input  logic               start_write_i,
    input  fx3_pkg::fx3_word_t pop_data_i,
    output logic               pop_o,
    output logic               write_done_o,
    fx3_bus_if.engine          bus
);

    localparam int CNT_W = $clog2(`FX3_BURST_LEN + 1);

    // armed waits for flagb, active moves words
    logic             armed;
    logic             active;
    logic [CNT_W-1:0] wr_cnt;

    // flaga low holds the write off
    assign pop_o      = active & bus.flaga;
    assign bus.slwr_n = ~pop_o;
    assign bus.wdata  = pop_data_i;

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            armed        <= 1'b0;
            active       <= 1'b0;
            wr_cnt       <= '0;
            write_done_o <= 1'b0;
        end else begin
            write_done_o <= 1'b0;
            if (start_write_i) begin
                armed  <= 1'b1;
                wr_cnt <= '0;
            end else if (armed && bus.flagb) begin
                armed  <= 1'b0;
                active <= 1'b1;
            end
            if (pop_o) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (wr_cnt == CNT_W'(`FX3_BURST_LEN - 1)) begin
                    active       <= 1'b0;
                    write_done_o <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/loop_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fx3_settings.svh"

module loop_fifo #(
    parameter int DEPTH = `FX3_FIFO_DEPTH
) (
    input  logic               usb_clk,
    input  logic               reset_,
    input  logic               push_i,
    input  fx3_pkg::fx3_word_t push_data_i,
    input  logic               pop_i,
    output fx3_pkg::fx3_word_t pop_data_o,
    output logic               empty_o,
    output logic               full_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    fx3_pkg::fx3_word_t mem [DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [AW:0]        count;

    always_ff @(posedge usb_clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge usb_clk or negedge reset_) begin
        if (!reset_) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // pointers wrap at depth, which need not be a power of two
            if (push_i) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(push_i) - (AW+1)'(pop_i);
        end
    end

    // show-ahead read
    assign pop_data_o = mem[rd_ptr];
    assign empty_o    = (count == '0);
    assign full_o     = (count == (AW+1)'(DEPTH));

    a_no_push_full: assert property (
        @(posedge usb_clk) disable iff (!reset_) push_i |-> !full_o
    );
    a_no_pop_empty: assert property (
        @(posedge usb_clk) disable iff (!reset_) pop_i |-> !empty_o
    );

endmodule

`default_nettype wire

/* hw/fx3_loopback_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fx3_loopback_top (
    input  logic                 usb_clk,
    input  logic                 reset_,
    input  logic                 flaga_i,
    input  logic                 flagb_i,
    input  logic                 flagc_i,
    input  logic                 flagd_i,
    input  fx3_pkg::fx3_word_t   data_i,
    output logic                 slcs_n_o,
    output logic                 slrd_n_o,
    output logic                 sloe_n_o,
    output logic                 slwr_n_o,
    output fx3_pkg::fx3_addr_e   addr_o,
    output fx3_pkg::fx3_word_t   data_o,
    output logic                 data_oe_o,
    output fx3_pkg::fx3_status_t led_o
);

    logic               start_read;
    logic               read_done;
    logic               start_write;
    logic               write_done;
    logic               push;
    logic               pop;
    logic               fifo_empty;
    fx3_pkg::fx3_word_t push_data;
    fx3_pkg::fx3_word_t pop_data;

    fx3_bus_if bus ();

    fx3_pin_io i_pin_io (
        .usb_clk   (usb_clk),
        .reset_    (reset_),
        .flaga_i   (flaga_i),
        .flagb_i   (flagb_i),
        .flagc_i   (flagc_i),
        .flagd_i   (flagd_i),
        .data_i    (data_i),
        .slcs_n_o  (slcs_n_o),
        .slrd_n_o  (slrd_n_o),
        .sloe_n_o  (sloe_n_o),
        .slwr_n_o  (slwr_n_o),
        .addr_o    (addr_o),
        .data_o    (data_o),
        .data_oe_o (data_oe_o),
        .bus       (bus.pin)
    );

    fx3_mode_fsm i_mode_fsm (
        .usb_clk       (usb_clk),
        .reset_        (reset_),
        .fifo_empty_i  (fifo_empty),
        .read_done_i   (read_done),
        .write_done_i  (write_done),
        .start_read_o  (start_read),
        .start_write_o (start_write),
        .led_o         (led_o),
        .bus           (bus.engine)
    );

    fx3_stream_out i_stream_out (
        .usb_clk      (usb_clk),
        .reset_       (reset_),
        .start_read_i (start_read),
        .push_o       (push),
        .push_data_o  (push_data),
        .read_done_o  (read_done),
        .bus          (bus.engine)
    );

    fx3_stream_in i_stream_in (
        .usb_clk       (usb_clk),
        .reset_        (reset_),
        .start_write_i (start_write),
        .pop_data_i    (pop_data),
        .pop_o         (pop),
        .write_done_o  (write_done),
        .bus           (bus.engine)
    );

    // full is only watched inside the fifo
    loop_fifo i_loop_fifo (
        .usb_clk     (usb_clk),
        .reset_      (reset_),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .empty_o     (fifo_empty),
        .full_o      ()
    );

endmodule

`default_nettype wire

/* tb/fx3_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fx3_settings.svh"

module fx3_model (
    input  logic               usb_clk,
    input  logic               slcs_n_i,
    input  logic               slrd_n_i,
    input  logic               slwr_n_i,
    input  fx3_pkg::fx3_word_t data_i,
    input  logic               load_i,
    input  fx3_pkg::fx3_word_t load_word_i,
    input  logic [31:0]        pause_mask_i,
    output logic               flaga_o,
    output logic               flagb_o,
    output logic               flagc_o,
    output logic               flagd_o,
    output fx3_pkg::fx3_word_t data_o,
    output logic               got_o,
    output fx3_pkg::fx3_word_t got_word_o
);

    localparam int RD_LAT = `FX3_RD_LAT;

    // outbound packet waiting in the fx3
    fx3_pkg::fx3_word_t out_q [$];
    logic [RD_LAT-1:0]  rd_seen;
    logic [4:0]         phase;

    // inbound socket never blocks on its own
    assign flagb_o = 1'b1;

    initial begin
        flaga_o    = 1'b0;
        flagc_o    = 1'b0;
        flagd_o    = 1'b0;
        data_o     = '0;
        got_o      = 1'b0;
        got_word_o = '0;
        rd_seen    = '0;
        phase      = '0;
    end

    always @(posedge usb_clk) begin
        // one bit per sampled read, word goes out RD_LAT cycles later
        rd_seen <= {rd_seen[RD_LAT-2:0], !slcs_n_i && !slrd_n_i};
        if (rd_seen[RD_LAT-2] && out_q.size() > 0) begin
            data_o <= out_q.pop_front();
        end
        if (load_i) begin
            out_q.push_back(load_word_i);
        end
        // full packet flags
        flagc_o <= (out_q.size() >= `FX3_BURST_LEN);
        flagd_o <= (out_q.size() >= `FX3_BURST_LEN);

        // flaga follows the pause pattern, a set bit holds writes off
        phase   <= phase + 1'b1;
        flaga_o <= !pause_mask_i[phase];

        // report each word written to the inbound socket
        got_o      <= !slcs_n_i && !slwr_n_i;
        got_word_o <= data_i;
    end

endmodule

`default_nettype wire

/* tb/tb_fx3_loopback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fx3_settings.svh"

module tb_fx3_loopback;

    localparam int NUM_ROWS   = 4;
    localparam int ROW_CYCLES = 4 * `FX3_BURST_LEN + `FX3_TURNAROUND + 50;
    localparam int MAX_CYCLES = NUM_ROWS * ROW_CYCLES + 20;

    logic                 usb_clk;
    logic                 reset_;
    logic                 flaga;
    logic                 flagb;
    logic                 flagc;
    logic                 flagd;
    fx3_pkg::fx3_word_t   fx3_data;
    logic                 slcs_n;
    logic                 slrd_n;
    logic                 sloe_n;
    logic                 slwr_n;
    fx3_pkg::fx3_addr_e   addr;
    fx3_pkg::fx3_word_t   dut_data;
    logic                 data_oe;
    fx3_pkg::fx3_status_t led;

    // model control and inbound report
    logic                 load;
    fx3_pkg::fx3_word_t   load_word;
    logic [31:0]          pause_mask;
    logic                 got;
    fx3_pkg::fx3_word_t   got_word;

    // test table, one row per loop
    string       row_name  [NUM_ROWS];
    int          row_delay [NUM_ROWS];
    logic [31:0] row_mask  [NUM_ROWS];

    fx3_pkg::fx3_word_t exp_q [$];
    fx3_pkg::fx3_word_t got_q [$];
    logic [31:0]        lfsr_state;
    string              cur_name     = "reset";
    int                 chk_errors   = 0;
    int                 mon_errors   = 0;
    int                 rd_strobes   = 0;
    int                 cycles       = 0;
    int                 tests_passed = 0;
    int                 tests_failed = 0;

    fx3_loopback_top i_dut (
        .usb_clk   (usb_clk),
        .reset_    (reset_),
        .flaga_i   (flaga),
        .flagb_i   (flagb),
        .flagc_i   (flagc),
        .flagd_i   (flagd),
        .data_i    (fx3_data),
        .slcs_n_o  (slcs_n),
        .slrd_n_o  (slrd_n),
        .sloe_n_o  (sloe_n),
        .slwr_n_o  (slwr_n),
        .addr_o    (addr),
        .data_o    (dut_data),
        .data_oe_o (data_oe),
        .led_o     (led)
    );

    fx3_model i_model (
        .usb_clk      (usb_clk),
        .slcs_n_i     (slcs_n),
        .slrd_n_i     (slrd_n),
        .slwr_n_i     (slwr_n),
        .data_i       (dut_data),
        .load_i       (load),
        .load_word_i  (load_word),
        .pause_mask_i (pause_mask),
        .flaga_o      (flaga),
        .flagb_o      (flagb),
        .flagc_o      (flagc),
        .flagd_o      (flagd),
        .data_o       (fx3_data),
        .got_o        (got),
        .got_word_o   (got_word)
    );

    initial begin
        usb_clk = 1'b0;
        forever #4 usb_clk = ~usb_clk;
    end

    always @(posedge usb_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: %0d cycles passed and the last loop did not finish", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // pin monitor, sampled away from the active edge
    always @(negedge usb_clk) begin
        if (reset_) begin
            if (!slrd_n) begin
                rd_strobes++;
                if (addr != fx3_pkg::addr_stream_out) begin
                    mon_errors++;
                    $display("Fail %s: addr_o in read expected %0d actual %0d",
                             cur_name, fx3_pkg::addr_stream_out, addr);
                end
                if (led != fx3_pkg::status_stream_out) begin
                    mon_errors++;
                    $display("Fail %s: led_o in read expected %0d actual %0d",
                             cur_name, fx3_pkg::status_stream_out, led);
                end
            end
            // output enable goes with every read strobe
            if (sloe_n != slrd_n) begin
                mon_errors++;
                $display("Fail %s: sloe_n_o expected %b actual %b",
                         cur_name, slrd_n, sloe_n);
            end
            if (!slwr_n && addr != fx3_pkg::addr_stream_in) begin
                mon_errors++;
                $display("Fail %s: addr_o in write expected %0d actual %0d",
                         cur_name, fx3_pkg::addr_stream_in, addr);
            end
            if (!slwr_n && led != fx3_pkg::status_stream_in) begin
                mon_errors++;
                $display("Fail %s: led_o in write expected %0d actual %0d",
                         cur_name, fx3_pkg::status_stream_in, led);
            end
            if (data_oe != !slwr_n) begin
                mon_errors++;
                $display("Fail %s: data_oe_o expected %b actual %b",
                         cur_name, !slwr_n, data_oe);
            end
            if (got) begin
                got_q.push_back(got_word);
            end
        end
    end

    // right shift galois, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_word(output fx3_pkg::fx3_word_t w);
        w = '0;
        for (int b = 0; b < `FX3_DATA_W; b++) begin
            w          = {w[`FX3_DATA_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        if (actual != expected) begin
            chk_errors++;
            $display("Fail %s: %s expected %0d actual %0d", cur_name, what, expected, actual);
        end
    endtask

    // no full packet yet, so the master must stay deselected
    task automatic expect_quiet();
        check_value("slcs_n_o without packet", 1, int'(slcs_n));
        check_value("slrd_n_o without packet", 1, int'(slrd_n));
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = chk_errors + mon_errors - errs_before;
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errs);
        end
    endtask

    task automatic run_row(input int r);
        int                 errs_before;
        int                 base_rd;
        int                 base_got;
        int                 n_got;
        fx3_pkg::fx3_word_t w;
        cur_name    = row_name[r];
        errs_before = chk_errors + mon_errors;
        base_rd     = rd_strobes;
        base_got    = got_q.size();
        exp_q.delete();
        @(posedge usb_clk);
        pause_mask <= row_mask[r];
        repeat (row_delay[r]) begin
            @(negedge usb_clk);
            expect_quiet();
        end
        // hand the burst to the fx3, flags rise after the last word
        for (int i = 0; i < `FX3_BURST_LEN; i++) begin
            draw_word(w);
            exp_q.push_back(w);
            @(posedge usb_clk);
            load      <= 1'b1;
            load_word <= w;
            @(negedge usb_clk);
            expect_quiet();
        end
        @(posedge usb_clk);
        load <= 1'b0;
        // chip select low marks the whole loop
        @(negedge usb_clk);
        while (slcs_n) begin
            @(negedge usb_clk);
        end
        while (!slcs_n) begin
            @(negedge usb_clk);
        end
        check_value("led_o after loop", int'(fx3_pkg::status_idle), int'(led));
        repeat (2) @(negedge usb_clk);
        check_value("slcs_n_o after loop", 1, int'(slcs_n));
        check_value("read strobes", `FX3_BURST_LEN, rd_strobes - base_rd);
        n_got = got_q.size() - base_got;
        check_value("words returned", `FX3_BURST_LEN, n_got);
        for (int i = 0; i < `FX3_BURST_LEN && i < n_got; i++) begin
            if (got_q[base_got + i] != exp_q[i]) begin
                chk_errors++;
                $display("Fail %s: word %0d expected %h actual %h",
                         cur_name, i, exp_q[i], got_q[base_got + i]);
            end
        end
        report_test(cur_name, errs_before);
    endtask

    initial begin
        reset_     = 1'b0;
        load       = 1'b0;
        load_word  = '0;
        pause_mask = '0;
        lfsr_state = 32'hd56ad592;

        row_name[0] = "back_to_back";
        row_delay[0] = 0;
        row_mask[0] = 32'h0000_0000;
        row_name[1] = "late_flags";
        row_delay[1] = 25;
        row_mask[1] = 32'h0000_0000;
        row_name[2] = "sparse_pause";
        row_delay[2] = 3;
        row_mask[2] = 32'h0100_8010;
        row_name[3] = "heavy_pause";
        row_delay[3] = 6;
        row_mask[3] = 32'h5555_5555;

        repeat (8) @(posedge usb_clk);
        reset_ <= 1'b1;
        @(negedge usb_clk);
        check_value("slcs_n_o", 1, int'(slcs_n));
        check_value("slrd_n_o", 1, int'(slrd_n));
        check_value("sloe_n_o", 1, int'(sloe_n));
        check_value("slwr_n_o", 1, int'(slwr_n));
        check_value("data_oe_o", 0, int'(data_oe));
        check_value("led_o", int'(fx3_pkg::status_idle), int'(led));
        check_value("addr_o", int'(fx3_pkg::addr_parked), int'(addr));
        report_test("reset", 0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, chk_errors + mon_errors);
        if (chk_errors + mon_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hw
hw/fx3_pkg.sv
hw/fx3_bus_if.sv
hw/fx3_pin_io.sv
hw/fx3_mode_fsm.sv
hw/fx3_stream_out.sv
hw/fx3_stream_in.sv
hw/loop_fifo.sv
hw/fx3_loopback_top.sv
tb/fx3_model.sv
tb/tb_fx3_loopback.sv

/* run.sh */
#!/bin/sh
# build and run the loopback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module tb_fx3_loopback

out=$(./obj_dir/Vtb_fx3_loopback 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
